//--- hdl/sdp_rdma_reg_pkg.sv
/*
 * register bus side definitions for the sdp read dma
 *   - register bus address and data types
 *   - line count type for the height field
 *   - register word address map
 */
package sdp_rdma_reg_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int CSB_AW     = 8;
  localparam int CSB_DW     = 32;
  localparam int LINE_CNT_W = 13;

  typedef logic [CSB_AW-1:0]     csb_addr_t;  // word address
  typedef logic [CSB_DW-1:0]     csb_data_t;
  typedef logic [LINE_CNT_W-1:0] line_cnt_t;  // lines minus one, or line index

  // ========================================
  // register map
  // ========================================
  localparam csb_addr_t REG_OP_ENABLE       = 8'd0;  // bit 0 only
  localparam csb_addr_t REG_FEATURE_MODE    = 8'd1;  // [0] flying, [1] bias off
  localparam csb_addr_t REG_SRC_BASE        = 8'd2;
  localparam csb_addr_t REG_SRC_LINE_STRIDE = 8'd3;
  localparam csb_addr_t REG_BS_BASE         = 8'd4;
  localparam csb_addr_t REG_BS_LINE_STRIDE  = 8'd5;
  localparam csb_addr_t REG_HEIGHT          = 8'd6;  // low 13 bits
  localparam csb_addr_t REG_DONE_COUNT      = 8'd7;  // read only

  // feature mode bit positions
  localparam int FEAT_FLYING_BIT  = 0;
  localparam int FEAT_BS_DIS_BIT  = 1;

endpackage

//--- hdl/sdp_rdma_dma_pkg.sv
/*
 * memory side definitions for the sdp read dma
 *   - read request address and response data types
 *   - latency FIFO depth, pointer and credit types
 */
package sdp_rdma_dma_pkg;

  localparam int DMA_AW = 32;
  localparam int DMA_DW = 64;

  typedef logic [DMA_AW-1:0] dma_addr_t;  // byte address
  typedef logic [DMA_DW-1:0] dma_data_t;  // one response word

  // ========================================
  // latency FIFO
  // ========================================
  localparam int LAT_FIFO_DEPTH = 4;
  localparam int LAT_PTR_W      = $clog2(LAT_FIFO_DEPTH);

  typedef logic [LAT_PTR_W-1:0] lat_ptr_t;
  typedef logic [2:0]           credit_t;  // 0 .. LAT_FIFO_DEPTH

  // count value meaning every entry is reserved
  localparam credit_t CREDIT_FULL = credit_t'(LAT_FIFO_DEPTH);

endpackage

//--- hdl/sdp_rdma_stream_if.sv
/*
 * response stream between latency FIFO and unpacker
 *   - valid/ready/data handshake with a derived pop strobe
 *   - source, sink and credit monitor views
 */
`timescale 1ns/1ps

interface sdp_rdma_stream_if
  import sdp_rdma_dma_pkg::*;
  ();

  logic      valid;
  logic      ready;
  dma_data_t data;
  logic      pop;

  assign pop = valid & ready;  // head leaves the fifo

  modport source  (output valid, output data, input ready, input pop);
  modport sink    (input valid, input data, input pop, output ready);
  modport monitor (input pop);   // credit return

endinterface

//--- hdl/sdp_rdma_reg.sv
/*
 * register file for the sdp read dma
 *   - write decode of configuration registers
 *   - registered read response
 *   - operation enable, cleared by completion
 *   - completed operation counter
 */
`timescale 1ns/1ps

module sdp_rdma_reg
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      csb_req_valid,
  input  logic      csb_req_write,
  input  csb_addr_t csb_req_addr,
  input  csb_data_t csb_req_wdata,
  input  logic      op_done,
  output logic      csb_resp_valid,
  output csb_data_t csb_resp_rdata,
  output logic      op_en,
  output logic      flying_mode,
  output logic      bs_disable,
  output dma_addr_t src_base,
  output dma_addr_t src_stride,
  output dma_addr_t bs_base,
  output dma_addr_t bs_stride,
  output line_cnt_t height
);

  logic      wr_en;
  logic      rd_en;
  csb_data_t done_cnt;
  csb_data_t rd_mux;

  assign wr_en = csb_req_valid & csb_req_write;
  assign rd_en = csb_req_valid & ~csb_req_write;

  // ========================================
  // writable registers
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en       <= 1'b0;
      flying_mode <= 1'b0;
      bs_disable  <= 1'b0;
      src_base    <= '0;
      src_stride  <= '0;
      bs_base     <= '0;
      bs_stride   <= '0;
      height      <= '0;
      done_cnt    <= '0;
    end else begin
      if (op_done) begin
        op_en <= 1'b0;                       // completion wins over a write
      end else if (wr_en && csb_req_addr == REG_OP_ENABLE) begin
        op_en <= csb_req_wdata[0];
      end
      if (op_done) begin
        done_cnt <= done_cnt + 32'd1;
      end
      if (wr_en) begin
        case (csb_req_addr)
          REG_FEATURE_MODE: begin
            flying_mode <= csb_req_wdata[FEAT_FLYING_BIT];
            bs_disable  <= csb_req_wdata[FEAT_BS_DIS_BIT];
          end
          REG_SRC_BASE:        src_base   <= dma_addr_t'(csb_req_wdata);
          REG_SRC_LINE_STRIDE: src_stride <= dma_addr_t'(csb_req_wdata);
          REG_BS_BASE:         bs_base    <= dma_addr_t'(csb_req_wdata);
          REG_BS_LINE_STRIDE:  bs_stride  <= dma_addr_t'(csb_req_wdata);
          REG_HEIGHT:          height     <= csb_req_wdata[LINE_CNT_W-1:0];
          default: ;                         // op enable handled above
        endcase
      end
    end
  end

  // ========================================
  // read path
  // ========================================
  always_comb begin
    case (csb_req_addr)
      REG_OP_ENABLE:       rd_mux = csb_data_t'(op_en);
      REG_FEATURE_MODE:    rd_mux = csb_data_t'({bs_disable, flying_mode});
      REG_SRC_BASE:        rd_mux = csb_data_t'(src_base);
      REG_SRC_LINE_STRIDE: rd_mux = csb_data_t'(src_stride);
      REG_BS_BASE:         rd_mux = csb_data_t'(bs_base);
      REG_BS_LINE_STRIDE:  rd_mux = csb_data_t'(bs_stride);
      REG_HEIGHT:          rd_mux = csb_data_t'(height);
      REG_DONE_COUNT:      rd_mux = done_cnt;
      default:             rd_mux = '0;      // unmapped
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= rd_en;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      csb_resp_rdata <= rd_mux;
    end
  end

endmodule

//--- hdl/sdp_rdma_req_gen.sv
/*
 * per engine read request generator
 *   - idle / issue / wait_done FSM
 *   - line address accumulator, base plus i times stride
 *   - credit count against the latency FIFO depth
 */
`timescale 1ns/1ps

module sdp_rdma_req_gen
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      op_en,
  input  dma_addr_t base,
  input  dma_addr_t stride,
  input  line_cnt_t height,
  input  logic      rd_req_ready,
  output logic      rd_req_valid,
  output dma_addr_t rd_req_addr,
  sdp_rdma_stream_if.monitor rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_DONE
  } state_t;

  state_t    state;
  dma_addr_t addr;
  line_cnt_t line_idx;
  credit_t   credits;
  logic      req_acc;
  logic      last_line;

  assign rd_req_valid = (state == ST_ISSUE) && (credits < CREDIT_FULL);
  assign rd_req_addr  = addr;
  assign req_acc      = rd_req_valid & rd_req_ready;
  assign last_line    = (line_idx == height);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state    <= ST_IDLE;
      line_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: if (op_en) begin
          state    <= ST_ISSUE;
          line_idx <= '0;
        end
        ST_ISSUE: if (req_acc) begin
          if (last_line) state <= ST_WAIT_DONE;
          line_idx <= line_idx + 13'd1;
        end
        ST_WAIT_DONE: if (!op_en) state <= ST_IDLE;  // engine marked done
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address accumulator
  always_ff @(posedge nvdla_core_clk) begin
    if (state == ST_IDLE) begin
      addr <= base;
    end else if (req_acc) begin
      addr <= addr + stride;
    end
  end

  // one credit per accepted request, returned on fifo pop
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      credits <= '0;
    end else begin
      credits <= credits + credit_t'(req_acc) - credit_t'(rsp.pop);
    end
  end

endmodule

//--- hdl/sdp_rdma_lat_fifo.sv
/*
 * per engine latency FIFO
 *   - circular buffer of LAT_FIFO_DEPTH read responses
 *   - simultaneous push and pop
 *   - ready to memory while not full
 */
`timescale 1ns/1ps

module sdp_rdma_lat_fifo
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      rd_rsp_valid,
  input  dma_data_t rd_rsp_data,
  output logic      rd_rsp_ready,
  sdp_rdma_stream_if.source rsp
);

  dma_data_t mem [LAT_FIFO_DEPTH];
  lat_ptr_t  wr_ptr;
  lat_ptr_t  rd_ptr;
  credit_t   count;
  logic      push;

  assign rd_rsp_ready = (count != CREDIT_FULL);
  assign push         = rd_rsp_valid & rd_rsp_ready;

  assign rsp.valid = (count != '0);
  assign rsp.data  = mem[rd_ptr];       // head, registered storage

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= rd_rsp_data;
    end
  end

  // ========================================
  // pointers and occupancy
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
      end
      if (rsp.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + credit_t'(push) - credit_t'(rsp.pop);
    end
  end

endmodule

//--- hdl/sdp_rdma_unpack.sv
/*
 * per engine datapath output stage
 *   - passes the FIFO head to the datapath while enabled
 *   - counts transferred lines
 *   - one cycle done pulse after the last line
 */
`timescale 1ns/1ps

module sdp_rdma_unpack
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      op_en,
  input  line_cnt_t height,
  input  logic      dp_ready,
  output logic      dp_valid,
  output dma_data_t dp_data,
  output logic      done,
  sdp_rdma_stream_if.sink rsp
);

  line_cnt_t line_cnt;
  logic      last_line;

  assign dp_valid  = op_en & rsp.valid;
  assign dp_data   = rsp.data;
  assign rsp.ready = op_en & dp_ready;
  assign last_line = (line_cnt == height);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= rsp.pop & last_line;     // single pulse
      if (rsp.pop) begin
        if (last_line) begin
          line_cnt <= '0;              // ready for the next operation
        end else begin
          line_cnt <= line_cnt + 13'd1;
        end
      end
    end
  end

endmodule

//--- hdl/sdp_rdma_done_ctrl.sv
/*
 * operation completion for the two read engines
 *   - done pending bit per engine
 *   - gated per engine enable
 *   - operation done when every engine is finished or disabled
 */
`timescale 1ns/1ps

module sdp_rdma_done_ctrl (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic op_en,
  input  logic flying_mode,
  input  logic bs_disable,
  input  logic src_done,
  input  logic bs_done,
  output logic src_op_en,
  output logic bs_op_en,
  output logic op_done
);

  logic src_pending;
  logic bs_pending;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      src_pending <= 1'b0;
      bs_pending  <= 1'b0;
    end else begin
      if (op_done)       src_pending <= 1'b0;
      else if (src_done) src_pending <= 1'b1;
      if (op_done)      bs_pending <= 1'b0;
      else if (bs_done) bs_pending <= 1'b1;
    end
  end

  // flying mode feeds the source from the core, so its reader sits out
  assign src_op_en = op_en & ~src_pending & ~flying_mode;
  assign bs_op_en  = op_en & ~bs_pending & ~bs_disable;

  assign op_done = op_en & (src_pending | src_done | flying_mode)
                         & (bs_pending | bs_done | bs_disable);

endmodule

//--- hdl/sdp_rdma.sv
/*
 * sdp read dma top level
 *   - register file and done controller
 *   - source and bias engine chains
 *     (request generator, latency FIFO, unpacker)
 */
`timescale 1ns/1ps

module sdp_rdma
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  // register bus
  input  logic      csb_req_valid,
  input  logic      csb_req_write,
  input  csb_addr_t csb_req_addr,
  input  csb_data_t csb_req_wdata,
  output logic      csb_resp_valid,
  output csb_data_t csb_resp_rdata,
  // source engine
  output logic      src_rd_req_valid,
  input  logic      src_rd_req_ready,
  output dma_addr_t src_rd_req_addr,
  input  logic      src_rd_rsp_valid,
  output logic      src_rd_rsp_ready,
  input  dma_data_t src_rd_rsp_data,
  output logic      src_dp_valid,
  input  logic      src_dp_ready,
  output dma_data_t src_dp_data,
  // bias engine
  output logic      bs_rd_req_valid,
  input  logic      bs_rd_req_ready,
  output dma_addr_t bs_rd_req_addr,
  input  logic      bs_rd_rsp_valid,
  output logic      bs_rd_rsp_ready,
  input  dma_data_t bs_rd_rsp_data,
  output logic      bs_dp_valid,
  input  logic      bs_dp_ready,
  output dma_data_t bs_dp_data,
  output logic      done
);

  logic      op_en;
  logic      op_done;
  logic      flying_mode;
  logic      bs_disable;
  logic      src_op_en;
  logic      bs_op_en;
  logic      src_done;
  logic      bs_done;
  dma_addr_t src_base;
  dma_addr_t src_stride;
  dma_addr_t bs_base;
  dma_addr_t bs_stride;
  line_cnt_t height;

  sdp_rdma_stream_if src_rsp_if ();
  sdp_rdma_stream_if bs_rsp_if ();

  assign done = op_done;

  // ========================================
  // control
  // ========================================
  sdp_rdma_reg u_reg (
    .nvdla_core_clk, .nvdla_core_rstn,
    .csb_req_valid, .csb_req_write, .csb_req_addr, .csb_req_wdata,
    .op_done, .csb_resp_valid, .csb_resp_rdata,
    .op_en, .flying_mode, .bs_disable,
    .src_base, .src_stride, .bs_base, .bs_stride, .height
  );

  sdp_rdma_done_ctrl u_done_ctrl (
    .nvdla_core_clk, .nvdla_core_rstn,
    .op_en, .flying_mode, .bs_disable, .src_done, .bs_done,
    .src_op_en, .bs_op_en, .op_done
  );

  // ========================================
  // source engine
  // ========================================
  sdp_rdma_req_gen u_src_req (
    .nvdla_core_clk, .nvdla_core_rstn,
    .op_en        (src_op_en),
    .base         (src_base),
    .stride       (src_stride),
    .height       (height),
    .rd_req_ready (src_rd_req_ready),
    .rd_req_valid (src_rd_req_valid),
    .rd_req_addr  (src_rd_req_addr),
    .rsp          (src_rsp_if.monitor)
  );

  sdp_rdma_lat_fifo u_src_fifo (
    .nvdla_core_clk, .nvdla_core_rstn,
    .rd_rsp_valid (src_rd_rsp_valid),
    .rd_rsp_data  (src_rd_rsp_data),
    .rd_rsp_ready (src_rd_rsp_ready),
    .rsp          (src_rsp_if.source)
  );

  sdp_rdma_unpack u_src_unpack (
    .nvdla_core_clk, .nvdla_core_rstn,
    .op_en    (src_op_en),
    .height   (height),
    .dp_ready (src_dp_ready),
    .dp_valid (src_dp_valid),
    .dp_data  (src_dp_data),
    .done     (src_done),
    .rsp      (src_rsp_if.sink)
  );

  // ========================================
  // bias engine
  // ========================================
  sdp_rdma_req_gen u_bs_req (
    .nvdla_core_clk, .nvdla_core_rstn,
    .op_en        (bs_op_en),
    .base         (bs_base),
    .stride       (bs_stride),
    .height       (height),
    .rd_req_ready (bs_rd_req_ready),
    .rd_req_valid (bs_rd_req_valid),
    .rd_req_addr  (bs_rd_req_addr),
    .rsp          (bs_rsp_if.monitor)
  );

  sdp_rdma_lat_fifo u_bs_fifo (
    .nvdla_core_clk, .nvdla_core_rstn,
    .rd_rsp_valid (bs_rd_rsp_valid),
    .rd_rsp_data  (bs_rd_rsp_data),
    .rd_rsp_ready (bs_rd_rsp_ready),
    .rsp          (bs_rsp_if.source)
  );

  sdp_rdma_unpack u_bs_unpack (
    .nvdla_core_clk, .nvdla_core_rstn,
    .op_en    (bs_op_en),
    .height   (height),
    .dp_ready (bs_dp_ready),
    .dp_valid (bs_dp_valid),
    .dp_data  (bs_dp_data),
    .done     (bs_done),
    .rsp      (bs_rsp_if.sink)
  );

endmodule

//--- test/tb_sdp_rdma.sv
/*
 * directed testbench for the sdp read dma
 *   - memory model with in-order random latency responses
 *   - request, datapath and done monitors
 *   - register, two-engine, disable, stall and reconfigure tests
 */
`timescale 1ns/1ps

module mem_model
  import sdp_rdma_dma_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      stall_en,
  input  logic      req_valid,
  input  dma_addr_t req_addr,
  output logic      req_ready,
  output logic      rsp_valid,
  output dma_data_t rsp_data,
  input  logic      rsp_ready
);

  dma_addr_t   addr_q[$];
  int unsigned due_q[$];
  int unsigned cycle = 0;
  int unsigned last_due = 0;
  int unsigned due;
  logic        ready_q = 1'b0;
  logic        valid_q = 1'b0;
  dma_data_t   data_q = '0;

  assign req_ready = ready_q;
  assign rsp_valid = valid_q;
  assign rsp_data  = data_q;

  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      if (req_valid && ready_q) begin
        due = cycle + $urandom_range(3, 0);
        if (due < last_due) due = last_due;  // answers stay in order
        last_due = due;
        addr_q.push_back(req_addr);
        due_q.push_back(due);
      end
      if (!valid_q || rsp_ready) begin      // response slot free
        if (addr_q.size() > 0 && due_q[0] <= cycle) begin
          data_q  <= {addr_q[0], ~addr_q[0]};
          valid_q <= 1'b1;
          void'(addr_q.pop_front());
          void'(due_q.pop_front());
        end else begin
          valid_q <= 1'b0;
        end
      end
      ready_q <= stall_en ? 1'($urandom_range(1, 0)) : 1'b1;
    end
  end

endmodule

module tb_sdp_rdma
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
();

  localparam int LINE_BUDGET     = 200;  // cycles per line
  localparam int MAX_OP_LINES    = 8;
  localparam int NUM_TESTS       = 5;
  // up to two operations per test
  localparam int WATCHDOG_CYCLES = LINE_BUDGET * MAX_OP_LINES * 2 * NUM_TESTS;

  logic      nvdla_core_clk;
  logic      nvdla_core_rstn;
  logic      csb_req_valid;
  logic      csb_req_write;
  csb_addr_t csb_req_addr;
  csb_data_t csb_req_wdata;
  logic      csb_resp_valid;
  csb_data_t csb_resp_rdata;
  logic      src_rd_req_valid;
  logic      src_rd_req_ready;
  dma_addr_t src_rd_req_addr;
  logic      src_rd_rsp_valid;
  logic      src_rd_rsp_ready;
  dma_data_t src_rd_rsp_data;
  logic      src_dp_valid;
  logic      src_dp_ready = 1'b0;
  dma_data_t src_dp_data;
  logic      bs_rd_req_valid;
  logic      bs_rd_req_ready;
  dma_addr_t bs_rd_req_addr;
  logic      bs_rd_rsp_valid;
  logic      bs_rd_rsp_ready;
  dma_data_t bs_rd_rsp_data;
  logic      bs_dp_valid;
  logic      bs_dp_ready = 1'b0;
  dma_data_t bs_dp_data;
  logic      done;

  logic        req_stall = 1'b0;
  logic        dp_stall = 1'b0;
  int unsigned done_pulses = 0;
  int unsigned done_mark;
  int unsigned exp_done_count = 0;
  string       engine_name [2] = '{"src", "bs"};
  logic        engine_on [2];
  dma_addr_t   exp_base [2];
  dma_addr_t   exp_stride [2];
  int unsigned req_cnt [2] = '{0, 0};
  int unsigned dp_cnt [2] = '{0, 0};
  int unsigned req_mark [2];
  int unsigned dp_mark [2];

  sdp_rdma dut_i (.*);

  mem_model src_mem_i (
    .nvdla_core_clk, .nvdla_core_rstn,
    .stall_en  (req_stall),
    .req_valid (src_rd_req_valid),
    .req_addr  (src_rd_req_addr),
    .req_ready (src_rd_req_ready),
    .rsp_valid (src_rd_rsp_valid),
    .rsp_data  (src_rd_rsp_data),
    .rsp_ready (src_rd_rsp_ready)
  );

  mem_model bs_mem_i (
    .nvdla_core_clk, .nvdla_core_rstn,
    .stall_en  (req_stall),
    .req_valid (bs_rd_req_valid),
    .req_addr  (bs_rd_req_addr),
    .req_ready (bs_rd_req_ready),
    .rsp_valid (bs_rd_rsp_valid),
    .rsp_data  (bs_rd_rsp_data),
    .rsp_ready (bs_rd_rsp_ready)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ========================================
  // error handling
  // ========================================
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge nvdla_core_clk);
    stop_on_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  // ========================================
  // monitors
  // ========================================
  function automatic dma_addr_t line_addr(input int e, input int unsigned idx);
    return exp_base[e] + exp_stride[e] * dma_addr_t'(idx);
  endfunction

  task automatic observe_engine(input int e, input logic req_fire, input dma_addr_t addr,
                                input logic dp_fire, input dma_data_t data);
    dma_addr_t exp_addr;
    if (req_fire) begin
      if (!engine_on[e]) begin
        stop_on_error($sformatf("%s engine issued a request while disabled", engine_name[e]));
      end
      exp_addr = line_addr(e, req_cnt[e] - req_mark[e]);
      check_value({engine_name[e], "_rd_req_addr"}, 64'(addr), 64'(exp_addr));
      req_cnt[e] = req_cnt[e] + 1;
    end
    if (dp_fire) begin
      exp_addr = line_addr(e, dp_cnt[e] - dp_mark[e]);
      check_value({engine_name[e], "_dp_data"}, data, {exp_addr, ~exp_addr});
      dp_cnt[e] = dp_cnt[e] + 1;
    end
    if (req_cnt[e] - dp_cnt[e] > LAT_FIFO_DEPTH) begin
      stop_on_error($sformatf("%s engine has more than %0d lines in flight",
                              engine_name[e], LAT_FIFO_DEPTH));
    end
  endtask

  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      observe_engine(0, src_rd_req_valid && src_rd_req_ready, src_rd_req_addr,
                     src_dp_valid && src_dp_ready, src_dp_data);
      observe_engine(1, bs_rd_req_valid && bs_rd_req_ready, bs_rd_req_addr,
                     bs_dp_valid && bs_dp_ready, bs_dp_data);
    end
  end

  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn && done) done_pulses <= done_pulses + 1;
  end

  // datapath sinks, random ready when stalling
  always @(posedge nvdla_core_clk) begin
    src_dp_ready <= dp_stall ? 1'($urandom_range(1, 0)) : 1'b1;
    bs_dp_ready  <= dp_stall ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  // ========================================
  // register bus access
  // ========================================
  task automatic csb_write(input csb_addr_t addr, input csb_data_t data);
    @(posedge nvdla_core_clk);
    csb_req_valid <= 1'b1;
    csb_req_write <= 1'b1;
    csb_req_addr  <= addr;
    csb_req_wdata <= data;
    @(posedge nvdla_core_clk);
    csb_req_valid <= 1'b0;
  endtask

  task automatic read_check(input csb_addr_t addr, input csb_data_t exp, input string name);
    int unsigned waited;
    waited = 0;
    @(posedge nvdla_core_clk);
    csb_req_valid <= 1'b1;
    csb_req_write <= 1'b0;
    csb_req_addr  <= addr;
    @(posedge nvdla_core_clk);
    csb_req_valid <= 1'b0;
    do begin
      @(posedge nvdla_core_clk);
      waited++;
      if (waited > 4) stop_on_error($sformatf("no read response for register %0d", addr));
    end while (!csb_resp_valid);
    check_value(name, 64'(csb_resp_rdata), 64'(exp));
  endtask

  // ========================================
  // one operation from configuration to done
  // ========================================
  task automatic run_op(input logic flying, input logic bs_off,
                        input dma_addr_t sbase, input dma_addr_t sstride,
                        input dma_addr_t bbase, input dma_addr_t bstride,
                        input line_cnt_t h);
    int unsigned lines;
    int unsigned cycles;
    lines  = int'(h) + 1;
    cycles = 0;
    csb_write(REG_FEATURE_MODE, {30'd0, bs_off, flying});
    csb_write(REG_SRC_BASE, sbase);
    csb_write(REG_SRC_LINE_STRIDE, sstride);
    csb_write(REG_BS_BASE, bbase);
    csb_write(REG_BS_LINE_STRIDE, bstride);
    csb_write(REG_HEIGHT, 32'(h));
    engine_on[0]  = !flying;
    engine_on[1]  = !bs_off;
    exp_base[0]   = sbase;
    exp_stride[0] = sstride;
    exp_base[1]   = bbase;
    exp_stride[1] = bstride;
    for (int e = 0; e < 2; e++) begin
      req_mark[e] = req_cnt[e];
      dp_mark[e]  = dp_cnt[e];
    end
    done_mark = done_pulses;
    csb_write(REG_OP_ENABLE, 32'd1);
    read_check(REG_OP_ENABLE, 32'd1, "op_enable while running");
    do begin
      @(posedge nvdla_core_clk);
      cycles++;
      if (cycles > LINE_BUDGET * lines) stop_on_error("done did not pulse in time");
    end while (!done);
    exp_done_count++;
    repeat (10) @(posedge nvdla_core_clk);  // catch a second pulse
    check_value("done pulses", 64'(done_pulses - done_mark), 64'd1);
    for (int e = 0; e < 2; e++) begin
      check_value({engine_name[e], " requests"}, 64'(req_cnt[e] - req_mark[e]),
                  64'(engine_on[e] ? lines : 0));
      check_value({engine_name[e], " transfers"}, 64'(dp_cnt[e] - dp_mark[e]),
                  64'(engine_on[e] ? lines : 0));
    end
    read_check(REG_OP_ENABLE, 32'd0, "op_enable after done");
    read_check(REG_DONE_COUNT, exp_done_count, "done_count");
  endtask

  // ========================================
  // tests
  // ========================================
  task automatic register_readback();
    read_check(REG_OP_ENABLE, 32'd0, "op_enable after reset");
    read_check(REG_DONE_COUNT, 32'd0, "done_count after reset");
    csb_write(REG_FEATURE_MODE, 32'h3);
    read_check(REG_FEATURE_MODE, 32'h3, "feature_mode");
    csb_write(REG_SRC_BASE, 32'h8000_1230);
    read_check(REG_SRC_BASE, 32'h8000_1230, "src_base");
    csb_write(REG_SRC_LINE_STRIDE, 32'h0000_0840);
    read_check(REG_SRC_LINE_STRIDE, 32'h0000_0840, "src_line_stride");
    csb_write(REG_BS_BASE, 32'h4000_0100);
    read_check(REG_BS_BASE, 32'h4000_0100, "bs_base");
    csb_write(REG_BS_LINE_STRIDE, 32'h0000_0020);
    read_check(REG_BS_LINE_STRIDE, 32'h0000_0020, "bs_line_stride");
    csb_write(REG_HEIGHT, 32'hffff_abcd);
    read_check(REG_HEIGHT, 32'h0000_0bcd, "height");       // 13 bits kept
    read_check(8'h08, 32'd0, "unmapped 0x08");
    read_check(8'hff, 32'd0, "unmapped 0xff");
    csb_write(REG_FEATURE_MODE, 32'h0);
  endtask

  task automatic dual_engine_op();
    run_op(1'b0, 1'b0, 32'h1000_0000, 32'h0000_0100, 32'h2000_0040, 32'h0000_0040, 13'd5);
  endtask

  task automatic engine_disables();
    run_op(1'b0, 1'b1, 32'h1100_0000, 32'h0000_0080, 32'h2100_0000, 32'h0000_0040, 13'd4);
    run_op(1'b1, 1'b0, 32'h1200_0000, 32'h0000_0080, 32'h2200_0000, 32'h0000_0020, 13'd3);
  endtask

  task automatic random_stalls();
    req_stall = 1'b1;
    dp_stall  = 1'b1;
    run_op(1'b0, 1'b0, 32'h3000_0000, 32'h0000_0200, 32'h3800_0000, 32'h0000_0010, 13'd7);
    req_stall = 1'b0;
    dp_stall  = 1'b0;
  endtask

  task automatic reconfigure_op();
    run_op(1'b0, 1'b0, 32'h4000_0000, 32'h0000_0100, 32'h4800_0000, 32'h0000_0100, 13'd2);
    run_op(1'b0, 1'b0, 32'h5000_0020, 32'h0000_0400, 32'h5800_0008, 32'h0000_0018, 13'd6);
  endtask

  initial begin
    void'($urandom(32'hc58b));
    nvdla_core_rstn <= 1'b0;
    csb_req_valid   <= 1'b0;
    csb_req_write   <= 1'b0;
    csb_req_addr    <= '0;
    csb_req_wdata   <= '0;
    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    register_readback();
    dual_engine_op();
    engine_disables();
    random_stalls();
    reconfigure_op();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- verilog.f
hdl/sdp_rdma_reg_pkg.sv
hdl/sdp_rdma_dma_pkg.sv
hdl/sdp_rdma_stream_if.sv
hdl/sdp_rdma_reg.sv
hdl/sdp_rdma_req_gen.sv
hdl/sdp_rdma_lat_fifo.sv
hdl/sdp_rdma_unpack.sv
hdl/sdp_rdma_done_ctrl.sv
hdl/sdp_rdma.sv
test/tb_sdp_rdma.sv

//--- Makefile
TOP = tb_sdp_rdma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f verilog.f --top-module sdp_rdma
	verilator --lint-only --timing -Wno-fatal -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST PASSED"

clean:
	rm -rf obj_dir
